// ==== verilog/riscv_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// riscv_pkg
// RV32 memory access encoding: data word, lane enables
// and the funct3 size codes used by loads and stores
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package riscv_pkg;

    // register and bus width of the rv32 core
    localparam int xlen = 32;

    // number of byte lanes in one data word
    localparam int word_bytes = xlen / 8;

    // one data word, used for store data, ram data and load results
    typedef logic [xlen-1:0] word_t;

    // one enable bit per byte lane, bit 0 is the least significant byte
    typedef logic [word_bytes-1:0] byte_en_t;

    // funct3 field of load and store instructions
    typedef logic [2:0] mem_funct3_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // size codes
    // ~~~~~~~~~~~~~~~~~~~~
    // the unsigned codes only make sense for loads, a store with one of them is illegal
    localparam mem_funct3_t funct3_lb  = 3'b000;
    localparam mem_funct3_t funct3_lh  = 3'b001;
    localparam mem_funct3_t funct3_lw  = 3'b010;
    localparam mem_funct3_t funct3_lbu = 3'b100;
    localparam mem_funct3_t funct3_lhu = 3'b101;

endpackage

`default_nettype wire

// ==== verilog/lsu_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// lsu_cfg_pkg
// memory geometry of the load/store unit and the
// address widths derived from it
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lsu_cfg_pkg;

    // depth of the data memory in words
    localparam int mem_words = 256;

    // bits needed to index one word of the memory
    localparam int word_addr_width = $clog2(mem_words);

    // low address bits that select a byte inside a word
    localparam int offset_width = 2;

    // full byte address as issued by the core
    typedef logic [31:0] byte_addr_t;

    // word index into the memory, upper address bits beyond it are ignored
    // so accesses wrap over the memory size
    typedef logic [word_addr_width-1:0] word_addr_t;

endpackage

`default_nettype wire

// ==== verilog/store_alignment.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// store_alignment
// input stage of the load/store unit: registers a request, decides
// the fault, and places store data and byte enables on their lanes
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module store_alignment
    import riscv_pkg::*;
    import lsu_cfg_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  logic                    req_store,
    input  mem_funct3_t             req_funct3,
    input  byte_addr_t              req_addr,
    input  word_t                   req_wdata,
    output logic                    mem_we,
    output byte_en_t                mem_be,
    output word_addr_t              mem_addr,
    output word_t                   mem_wdata,
    output logic                    stage_valid,
    output logic                    stage_load,
    output logic                    stage_fault,
    output mem_funct3_t             stage_funct3,
    output logic [offset_width-1:0] stage_offset
);

    logic                    is_byte;
    logic                    is_half;
    logic                    is_word;
    logic                    is_unsigned;
    logic                    fault;
    logic [offset_width-1:0] offset;
    byte_en_t                lane_be;
    word_t                   lane_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // size decode and fault check
    // ~~~~~~~~~~~~~~~~~~~~
    assign offset      = req_addr[offset_width-1:0];
    assign is_byte     = (req_funct3 == funct3_lb) || (req_funct3 == funct3_lbu);
    assign is_half     = (req_funct3 == funct3_lh) || (req_funct3 == funct3_lhu);
    assign is_word     = (req_funct3 == funct3_lw);
    assign is_unsigned = (req_funct3 == funct3_lbu) || (req_funct3 == funct3_lhu);

    // this is the only place a fault is decided, later stages just carry the flag
    // illegal code, unsigned store, odd halfword or unaligned word
    assign fault = ~(is_byte | is_half | is_word)
                 | (req_store & is_unsigned)
                 | (is_half & offset[0])
                 | (is_word & (offset != '0));

    // ~~~~~~~~~~~~~~~~~~~~
    // lane placement
    // ~~~~~~~~~~~~~~~~~~~~
    // the byte or halfword is copied to every lane it could land on,
    // the enables then pick the lane(s) that actually get written
    always_comb begin
        if (is_byte) begin
            lane_data = {word_bytes{req_wdata[7:0]}};
            lane_be   = byte_en_t'(1) << offset;
        end else if (is_half) begin
            lane_data = {(word_bytes / 2){req_wdata[15:0]}};
            lane_be   = offset[1] ? 4'b1100 : 4'b0011;
        end else begin
            // word access, an illegal code is faulted and never written
            lane_data = req_wdata;
            lane_be   = '1;
        end
    end

    // strobes are cleared on reset, a write is only allowed for a clean store
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
            mem_we      <= 1'b0;
        end else begin
            stage_valid <= req_valid;
            mem_we      <= req_valid & req_store & ~fault;
        end
    end

    // payload and metadata, only meaningful while stage_valid is set
    always_ff @(posedge clk) begin
        mem_be       <= lane_be;
        mem_addr     <= req_addr[offset_width +: word_addr_width];
        mem_wdata    <= lane_data;
        stage_load   <= ~req_store;
        stage_fault  <= fault;
        stage_funct3 <= req_funct3;
        stage_offset <= offset;
    end

endmodule

`default_nettype wire

// ==== verilog/data_memory.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data_memory
// word-wide RAM with byte enables and a registered read,
// carries the request metadata along for one cycle
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module data_memory
    import riscv_pkg::*;
    import lsu_cfg_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mem_we,
    input  byte_en_t                mem_be,
    input  word_addr_t              mem_addr,
    input  word_t                   mem_wdata,
    input  logic                    stage_valid,
    input  logic                    stage_load,
    input  logic                    stage_fault,
    input  mem_funct3_t             stage_funct3,
    input  logic [offset_width-1:0] stage_offset,
    output word_t                   rd_data,
    output logic                    rd_valid,
    output logic                    rd_load,
    output logic                    rd_fault,
    output mem_funct3_t             rd_funct3,
    output logic [offset_width-1:0] rd_offset
);

    // storage, contents are left as they are on reset
    word_t mem [mem_words];

    // ~~~~~~~~~~~~~~~~~~~~
    // ram array
    // ~~~~~~~~~~~~~~~~~~~~
    // every lane is written on its own enable
    // the read happens on the same edge, so a read of a word being written
    // returns the old contents
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < word_bytes; lane++) begin
            if (mem_we && mem_be[lane]) begin
                mem[mem_addr][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
            end
        end
        rd_data <= mem[mem_addr];
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // metadata pipeline
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= stage_valid;
        end
    end

    // these only travel next to rd_valid and need no clearing
    always_ff @(posedge clk) begin
        rd_load   <= stage_load;
        rd_fault  <= stage_fault;
        rd_funct3 <= stage_funct3;
        rd_offset <= stage_offset;
    end

endmodule

`default_nettype wire

// ==== verilog/load_alignment.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// load_alignment
// output stage: picks the addressed byte or halfword out of the
// read word, extends it and registers the response
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module load_alignment
    import riscv_pkg::*;
    import lsu_cfg_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  word_t                   rd_data,
    input  logic                    rd_valid,
    input  logic                    rd_load,
    input  logic                    rd_fault,
    input  mem_funct3_t             rd_funct3,
    input  logic [offset_width-1:0] rd_offset,
    output logic                    rsp_valid,
    output word_t                   rsp_data,
    output logic                    rsp_fault
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t       load_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // lane select
    // ~~~~~~~~~~~~~~~~~~~~
    // the byte comes from the lane given by the offset,
    // the halfword only depends on offset bit 1 since bit 0 is checked upstream
    assign sel_byte = rd_data[{rd_offset, 3'b000} +: 8];
    assign sel_half = rd_offset[1] ? rd_data[31:16] : rd_data[15:0];

    always_comb begin
        case (rd_funct3)
            funct3_lb:  load_data = {{(xlen - 8){sel_byte[7]}}, sel_byte};
            funct3_lbu: load_data = {{(xlen - 8){1'b0}}, sel_byte};
            funct3_lh:  load_data = {{(xlen - 16){sel_half[15]}}, sel_half};
            funct3_lhu: load_data = {{(xlen - 16){1'b0}}, sel_half};
            funct3_lw:  load_data = rd_data;
            // illegal codes are always faulted, so zero is what gets returned anyway
            default:    load_data = '0;
        endcase

        // stores and faulted requests answer with zero data
        if (!rd_load || rd_fault) begin
            load_data = '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // response register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
            rsp_fault <= 1'b0;
        end else begin
            rsp_valid <= rd_valid;
            rsp_fault <= rd_valid & rd_fault;
        end
    end

    // data is qualified by rsp_valid
    always_ff @(posedge clk) begin
        rsp_data <= load_data;
    end

endmodule

`default_nettype wire

// ==== verilog/load_store_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// load_store_unit
// data memory path of the multicycle core, one request in per
// cycle and one response out two cycles later
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module load_store_unit
    import riscv_pkg::*;
    import lsu_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  logic        req_store,
    input  mem_funct3_t req_funct3,
    input  byte_addr_t  req_addr,
    input  word_t       req_wdata,
    output logic        rsp_valid,
    output word_t       rsp_data,
    output logic        rsp_fault
);

    // ~~~~~~~~~~~~~~~~~~~~
    // request stage to ram
    // ~~~~~~~~~~~~~~~~~~~~
    logic                    mem_we;
    byte_en_t                mem_be;
    word_addr_t              mem_addr;
    word_t                   mem_wdata;
    logic                    stage_valid;
    logic                    stage_load;
    logic                    stage_fault;
    mem_funct3_t             stage_funct3;
    logic [offset_width-1:0] stage_offset;

    // ~~~~~~~~~~~~~~~~~~~~
    // ram to response stage
    // ~~~~~~~~~~~~~~~~~~~~
    word_t                   rd_data;
    logic                    rd_valid;
    logic                    rd_load;
    logic                    rd_fault;
    mem_funct3_t             rd_funct3;
    logic [offset_width-1:0] rd_offset;

    // checks the request and lines the store data up with its lanes
    store_alignment i_store_alignment (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_store    (req_store),
        .req_funct3   (req_funct3),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .mem_we       (mem_we),
        .mem_be       (mem_be),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .stage_valid  (stage_valid),
        .stage_load   (stage_load),
        .stage_fault  (stage_fault),
        .stage_funct3 (stage_funct3),
        .stage_offset (stage_offset)
    );

    // one read or one write per cycle, metadata rides alongside
    data_memory i_data_memory (
        .clk          (clk),
        .reset        (reset),
        .mem_we       (mem_we),
        .mem_be       (mem_be),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .stage_valid  (stage_valid),
        .stage_load   (stage_load),
        .stage_fault  (stage_fault),
        .stage_funct3 (stage_funct3),
        .stage_offset (stage_offset),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .rd_load      (rd_load),
        .rd_fault     (rd_fault),
        .rd_funct3    (rd_funct3),
        .rd_offset    (rd_offset)
    );

    // extracts the load result and drives the response
    load_alignment i_load_alignment (
        .clk       (clk),
        .reset     (reset),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_load   (rd_load),
        .rd_fault  (rd_fault),
        .rd_funct3 (rd_funct3),
        .rd_offset (rd_offset),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_fault (rsp_fault)
    );

endmodule

`default_nettype wire

// ==== tb/load_store_unit_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// load_store_unit_asserts
// protocol checks on the top-level ports of the load/store unit
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module load_store_unit_asserts
    import riscv_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  req_valid,
    input logic  rsp_valid,
    input word_t rsp_data,
    input logic  rsp_fault
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of assertion failures, watched by the testbench on every falling edge
    int fail_count = 0;

    // the response strobe is cleared by reset and stays low right after it
    a_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !rsp_valid)
        else begin
            $error("rsp_valid is high in the first cycle after reset");
            fail_count++;
        end

    // a request sampled at one edge is answered by a strobe sampled three edges later
    a_rsp_follows_req: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> ##3 rsp_valid)
        else begin
            $error("no rsp_valid for a request");
            fail_count++;
        end

    // and no strobe shows up without a request in front of it
    a_no_stray_rsp: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> $past(req_valid, 3))
        else begin
            $error("rsp_valid without a matching request");
            fail_count++;
        end

    // faulted requests return zero data
    a_fault_zero_data: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && rsp_fault) |-> (rsp_data == '0))
        else begin
            $error("rsp_data is nonzero on a faulted response");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== tb/tb_load_store_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// tb_load_store_unit
// self-checking testbench: drives requests from an LFSR, keeps a
// reference memory and compares every response in order
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_load_store_unit
    import riscv_pkg::*;
    import lsu_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~
    // test lengths
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int pair_count   = 16;
    localparam int lane_words   = 8;
    localparam int sweep_words  = 2;
    localparam int random_count = 400;
    // fill, store/load pairs, lane tests, fault sweep and the random mix
    localparam int num_requests = mem_words + 2 * pair_count + 17 * lane_words
                                + 65 * sweep_words + random_count;
    localparam int watchdog_margin = 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        req_valid;
    logic        req_store;
    mem_funct3_t req_funct3;
    byte_addr_t  req_addr;
    word_t       req_wdata;
    logic        rsp_valid;
    word_t       rsp_data;
    logic        rsp_fault;

    // reference memory and the expected responses still in flight
    word_t       ref_mem [mem_words];
    word_t       exp_data_q [$];
    logic        exp_fault_q [$];
    int          exp_due_q [$];
    int          cycle_count = 0;
    int          checked_count = 0;
    logic [31:0] lfsr_state = 32'h2e99;

    always #5 clk = ~clk;

    // counted on the rising edge and read on the falling one, where it is stable
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    load_store_unit i_load_store_unit (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_store  (req_store),
        .req_funct3 (req_funct3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_fault  (rsp_fault)
    );

    bind load_store_unit load_store_unit_asserts i_asserts (.*);

    // ~~~~~~~~~~~~~~~~~~~~
    // random source
    // ~~~~~~~~~~~~~~~~~~~~
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit, the new bit is shifted in at the bottom
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~
    // a store replaces only the bytes covered by its size, shifted to its offset
    function automatic word_t merge_store(input word_t old, input mem_funct3_t f3,
                                          input logic [1:0] off, input word_t wdata);
        word_t mask;
        if (f3 == funct3_lb) begin
            mask = 32'h0000_00ff;
        end else if (f3 == funct3_lh) begin
            mask = 32'h0000_ffff;
        end else begin
            mask = 32'hffff_ffff;
        end
        mask = mask << (off * 8);
        return (old & ~mask) | ((wdata << (off * 8)) & mask);
    endfunction

    // returns {fault, data} for a request against the current model contents
    function automatic logic [32:0] expected_response(input logic store,
                                                      input mem_funct3_t f3,
                                                      input byte_addr_t addr);
        logic       fault;
        word_t      w;
        word_t      data;
        logic [1:0] off;
        off = addr[1:0];
        w = ref_mem[(addr >> 2) % mem_words];
        case (f3)
            funct3_lb, funct3_lbu: fault = store && (f3 == funct3_lbu);
            funct3_lh, funct3_lhu: fault = off[0] || (store && (f3 == funct3_lhu));
            funct3_lw:             fault = (off != 2'b00);
            default:               fault = 1'b1;
        endcase
        // bring the addressed item down to bit 0, then extend it
        w = w >> (off * 8);
        case (f3)
            funct3_lb:  data = {{24{w[7]}}, w[7:0]};
            funct3_lbu: data = {24'h0, w[7:0]};
            funct3_lh:  data = {{16{w[15]}}, w[15:0]};
            funct3_lhu: data = {16'h0, w[15:0]};
            default:    data = w;
        endcase
        if (store || fault) begin
            data = '0;
        end
        return {fault, data};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // error reporting
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            fail_and_stop($sformatf("FAILED %s: got 0x%08h expected 0x%08h",
                                    name, actual, expected));
        end
    endtask

    task automatic check_fault(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_and_stop($sformatf("FAILED %s: got 0x%0h expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    // drives one request on the falling edge and records what must come back
    task automatic issue(input logic store, input mem_funct3_t f3,
                         input byte_addr_t addr, input word_t wdata);
        logic [32:0] exp;
        int          idx;
        @(negedge clk);
        exp = expected_response(store, f3, addr);
        if (store && !exp[32]) begin
            idx = (addr >> 2) % mem_words;
            ref_mem[idx] = merge_store(ref_mem[idx], f3, addr[1:0], wdata);
        end
        exp_data_q.push_back(exp[31:0]);
        exp_fault_q.push_back(exp[32]);
        // visible on the falling edge three rising edges from now
        exp_due_q.push_back(cycle_count + 3);
        req_valid  = 1'b1;
        req_store  = store;
        req_funct3 = f3;
        req_addr   = addr;
        req_wdata  = wdata;
    endtask

    task automatic idle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // responses come in request order, so the oldest entry is always the next one
    // a failed port assertion stops the run at the next falling edge
    always @(negedge clk) begin
        if (i_load_store_unit.i_asserts.fail_count != 0) begin
            fail_and_stop("a port assertion on the DUT failed");
        end
        if (!reset) begin
            if (rsp_valid === 1'b1) begin
                if (exp_data_q.size() == 0) begin
                    fail_and_stop("a response appeared with no request outstanding");
                end else begin
                    if (exp_due_q[0] != cycle_count) begin
                        fail_and_stop("a response arrived in the wrong cycle");
                    end
                    check_word("rsp_data", rsp_data, exp_data_q.pop_front());
                    check_fault("rsp_fault", rsp_fault, exp_fault_q.pop_front());
                    void'(exp_due_q.pop_front());
                    checked_count++;
                end
            end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_count) begin
                fail_and_stop("an expected response did not arrive");
            end
        end
    end

    initial begin
        repeat (num_requests * 10 + watchdog_margin) @(posedge clk);
        fail_and_stop("watchdog expired before the test finished");
    end

    initial begin
        byte_addr_t  base;
        byte_addr_t  addr;
        word_t       data;
        logic        store;
        mem_funct3_t f3;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_funct3 = '0;
        req_addr   = '0;
        req_wdata  = '0;
        reset      = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // every word gets a known value, mixed with its index so no two words match
        for (int i = 0; i < mem_words; i++) begin
            data = random_bits(32) ^ {4{i[7:0]}};
            issue(1'b1, funct3_lw, byte_addr_t'(i * 4), data);
        end

        // word store then word load in the next cycle, upper address bits wrap
        for (int n = 0; n < pair_count; n++) begin
            addr = random_bits(30) << 2;
            data = random_bits(32);
            issue(1'b1, funct3_lw, addr, data);
            issue(1'b0, funct3_lw, addr, '0);
        end

        // partial stores, merged word reads and extended loads at every offset
        for (int k = 0; k < lane_words; k++) begin
            base = random_bits(30) << 2;
            data = random_bits(16);
            data[15] = k[0];
            issue(1'b1, funct3_lh, base + 2 * k[1], data);
            issue(1'b0, funct3_lw, base, '0);
            for (int j = 0; j < 2; j++) begin
                data = random_bits(8);
                data[7] = k[0] ^ j[0];
                issue(1'b1, funct3_lb, base + ((k + 2 * j) % 4), data);
            end
            issue(1'b0, funct3_lw, base, '0);
            for (int b = 0; b < 4; b++) begin
                issue(1'b0, funct3_lb, base + b, '0);
                issue(1'b0, funct3_lbu, base + b, '0);
            end
            for (int h = 0; h < 2; h++) begin
                issue(1'b0, funct3_lh, base + 2 * h, '0);
                issue(1'b0, funct3_lhu, base + 2 * h, '0);
            end
        end

        // every code at every offset as load and store, then read the word back
        for (int w = 0; w < sweep_words; w++) begin
            base = random_bits(30) << 2;
            for (int c = 0; c < 8; c++) begin
                for (int o = 0; o < 4; o++) begin
                    for (int s = 0; s < 2; s++) begin
                        data = random_bits(32);
                        issue(s[0], mem_funct3_t'(c), base + o, data);
                    end
                end
            end
            issue(1'b0, funct3_lw, base, '0);
        end

        // random mix, mostly back to back with an occasional idle cycle
        for (int n = 0; n < random_count; n++) begin
            if (random_bits(2) == 0) begin
                idle();
            end
            store = random_bits(1);
            f3    = random_bits(3);
            addr  = random_bits(32);
            if (random_bits(1)) begin
                addr[1:0] = 2'b00;
            end
            data = random_bits(32);
            issue(store, f3, addr, data);
        end

        // the last response is due three rising edges after its request
        idle();
        repeat (4) @(negedge clk);

        if (exp_data_q.size() != 0) begin
            fail_and_stop("responses were still missing at the end of the run");
        end else if (i_load_store_unit.i_asserts.fail_count != 0) begin
            fail_and_stop("one or more port assertions failed");
        end else begin
            $display("%0d responses checked", checked_count);
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/riscv_pkg.sv
verilog/lsu_cfg_pkg.sv
verilog/store_alignment.sv
verilog/data_memory.sv
verilog/load_alignment.sv
verilog/load_store_unit.sv
tb/load_store_unit_asserts.sv
tb/tb_load_store_unit.sv
